/* src/dtree_cfg_pkg.sv */
`default_nettype none

package dtree_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Job limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int max_features       = 16;
  localparam int max_depth          = 4;
  localparam int max_trees          = 8;
  localparam int feats_per_beat     = 4;
  // Internal nodes, then leaves, of a full tree at max depth
  localparam int nodes_per_tree_max = 15;
  localparam int beats_per_tree_max = 31;

  // Widths with a meaning
  typedef logic signed [15:0] feature_t;
  typedef logic signed [15:0] threshold_t;
  typedef logic        [3:0]  feat_idx_t;
  typedef logic        [4:0]  feat_cnt_t;
  typedef logic signed [31:0] leaf_t;
  // Wraps on overflow
  typedef logic        [31:0] result_t;
  typedef logic        [2:0]  depth_t;
  typedef logic        [3:0]  tree_cnt_t;
  typedef logic        [31:0] tuple_cnt_t;
  // 8 trees x 31 beats
  typedef logic        [7:0]  node_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  // Write bit 0 starts, read bit 0 busy, bit 1 done
  localparam logic [7:0] reg_ctrl         = 8'h00;
  localparam logic [7:0] reg_num_features = 8'h04;
  localparam logic [7:0] reg_tree_depth   = 8'h08;
  localparam logic [7:0] reg_num_trees    = 8'h0C;
  localparam logic [7:0] reg_num_tuples   = 8'h10;

  // Job parameters seen by the datapath
  typedef struct packed {
    feat_cnt_t  num_features;
    depth_t     tree_depth;
    tree_cnt_t  num_trees;
    tuple_cnt_t num_tuples;
  } job_cfg_t;

endpackage

`default_nettype wire

/* src/dtree_bus_pkg.sv */
`default_nettype none

package dtree_bus_pkg;

  localparam int axis_data_w = 64;
  localparam int axil_addr_w = 8;
  localparam int axil_data_w = 32;

  // One host stream beat
  typedef struct packed {
    logic [axis_data_w-1:0]   tdata;
    logic [axis_data_w/8-1:0] tkeep;
    logic                     tlast;
  } axis_beat_t;

  // AXI4-Lite, master to slave
  typedef struct packed {
    logic [axil_addr_w-1:0] awaddr;
    logic                   awvalid;
    logic [axil_data_w-1:0] wdata;
    logic                   wvalid;
    logic                   bready;
    logic [axil_addr_w-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  // AXI4-Lite, slave to master
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic [axil_data_w-1:0] rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* src/axis_reg_slice.sv */
`default_nettype none
`timescale 1ns/1ps

module axis_reg_slice #(
  parameter type beat_t = dtree_bus_pkg::axis_beat_t
) (
  input  wire        aclk,
  input  wire        aresetn,
  input  wire beat_t in_beat,
  input  wire        in_valid,
  output logic       in_ready,
  output beat_t      out_beat,
  output logic       out_valid,
  input  wire        out_ready
);

  // Skid entry catches the beat taken while the output stalls
  beat_t main_q;
  beat_t skid_q;
  logic  skid_valid;
  logic  skid_next;
  logic  in_fire;
  logic  out_free;

  assign in_fire  = in_valid && in_ready;
  assign out_free = !out_valid || out_ready;
  assign out_beat = main_q;

  // Skid fills only on a stalled output
  assign skid_next = out_free ? 1'b0 : (skid_valid || in_fire);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else begin
      skid_valid <= skid_next;
      // Registered ready, breaks the backward path
      in_ready   <= !skid_next;
      if (out_free) begin
        out_valid <= skid_valid || in_fire;
      end
    end
  end

  // Payload path
  always_ff @(posedge aclk) begin
    if (out_free) begin
      main_q <= skid_valid ? skid_q : in_beat;
    end else if (in_fire) begin
      skid_q <= in_beat;
    end
  end

endmodule

`default_nettype wire

/* src/dtree_csr.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_csr (
  input  wire                           aclk,
  input  wire                           aresetn,
  input  wire dtree_bus_pkg::axil_req_t axil_req,
  output dtree_bus_pkg::axil_rsp_t      axil_rsp,
  input  wire                           job_done,
  output dtree_cfg_pkg::job_cfg_t       cfg,
  output logic                          start
);

  import dtree_cfg_pkg::*;
  import dtree_bus_pkg::*;

  logic                   aw_held;
  logic                   w_held;
  logic [axil_addr_w-1:0] aw_addr_q;
  logic [axil_data_w-1:0] w_data_q;
  logic                   bvalid;
  logic                   rvalid;
  logic [axil_data_w-1:0] rdata_q;
  logic [axil_data_w-1:0] rd_mux;
  logic                   wr_go;
  logic                   ar_fire;
  logic                   busy;
  logic                   done;

  ////////////////////////////////////////////////////////////////////////////
  // Channel handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Address and data latch on their own, write once both are in
  assign wr_go   = aw_held && w_held && !bvalid;
  assign ar_fire = axil_req.arvalid && !rvalid;

  always_comb begin
    axil_rsp.awready = !aw_held;
    axil_rsp.wready  = !w_held;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = !rvalid;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = 2'b00;
    axil_rsp.rvalid  = rvalid;
  end

  // Read decode, unmapped reads zero
  always_comb begin
    case (axil_req.araddr)
      reg_ctrl:         rd_mux = {30'd0, done, busy};
      reg_num_features: rd_mux = 32'(cfg.num_features);
      reg_tree_depth:   rd_mux = 32'(cfg.tree_depth);
      reg_num_trees:    rd_mux = 32'(cfg.num_trees);
      reg_num_tuples:   rd_mux = cfg.num_tuples;
      default:          rd_mux = '0;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      start   <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      cfg     <= '0;
    end else begin
      start <= 1'b0;
      if (axil_req.awvalid && !aw_held) aw_held <= 1'b1;
      if (axil_req.wvalid && !w_held) w_held <= 1'b1;
      if (bvalid && axil_req.bready) bvalid <= 1'b0;
      if (wr_go) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        bvalid  <= 1'b1;
        case (aw_addr_q)
          // Start ignored during a job
          reg_ctrl:         start <= w_data_q[0] && !busy;
          reg_num_features: cfg.num_features <= feat_cnt_t'(w_data_q);
          reg_tree_depth:   cfg.tree_depth <= depth_t'(w_data_q);
          reg_num_trees:    cfg.num_trees <= tree_cnt_t'(w_data_q);
          reg_num_tuples:   cfg.num_tuples <= w_data_q;
          default:          ;
        endcase
      end
      if (ar_fire) rvalid <= 1'b1;
      else if (rvalid && axil_req.rready) rvalid <= 1'b0;
      // Status flags
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end
      if (job_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Held address, data and read word
  always_ff @(posedge aclk) begin
    if (axil_req.awvalid && !aw_held) aw_addr_q <= axil_req.awaddr;
    if (axil_req.wvalid && !w_held) w_data_q <= axil_req.wdata;
    if (ar_fire) rdata_q <= rd_mux;
  end

endmodule

`default_nettype wire

/* src/dtree_input_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_input_sequencer (
  input  wire                                   aclk,
  input  wire                                   aresetn,
  input  wire                                   start,
  input  wire dtree_bus_pkg::axis_beat_t        in_beat,
  input  wire                                   in_valid,
  output logic                                  in_ready,
  output logic                                  tree_wr_valid,
  output logic [dtree_bus_pkg::axis_data_w-1:0] tree_data,
  output logic                                  tuple_valid,
  input  wire                                   tuple_ready,
  output logic [dtree_bus_pkg::axis_data_w-1:0] tuple_data,
  output logic                                  tuple_last,
  output logic                                  busy
);

  typedef enum logic [1:0] {IDLE, LOAD_TREES, SWITCH, LOAD_DATA} seq_state_t;

  seq_state_t state;
  logic       last_fire;

  // Tree beats never wait, tuple beats follow the engine
  assign in_ready = (state == LOAD_TREES) || ((state == LOAD_DATA) && tuple_ready);
  assign last_fire = in_valid && in_ready && in_beat.tlast;

  assign tree_wr_valid = (state == LOAD_TREES) && in_valid;
  assign tree_data     = in_beat.tdata;
  assign tuple_valid   = (state == LOAD_DATA) && in_valid;
  assign tuple_data    = in_beat.tdata;
  assign tuple_last    = in_beat.tlast;

  // Reader phase only, the CSR flag lasts until job_done
  assign busy = (state != IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // Reader FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:       if (start) state <= LOAD_TREES;
        // tlast closes the tree phase
        LOAD_TREES: if (last_fire) state <= SWITCH;
        // One cycle gap before tuples
        SWITCH:     state <= LOAD_DATA;
        LOAD_DATA:  if (last_fire) state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/dtree_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_engine (
  input  wire                                  aclk,
  input  wire                                  aresetn,
  input  wire dtree_cfg_pkg::job_cfg_t         cfg,
  input  wire                                  start,
  input  wire                                  tree_wr_valid,
  input  wire [dtree_bus_pkg::axis_data_w-1:0] tree_data,
  input  wire                                  tuple_valid,
  output logic                                 tuple_ready,
  input  wire [dtree_bus_pkg::axis_data_w-1:0] tuple_data,
  input  wire                                  tuple_last,
  output dtree_cfg_pkg::result_t               res,
  output logic                                 res_valid,
  input  wire                                  res_ready
);

  import dtree_cfg_pkg::*;

  typedef enum logic [1:0] {FILL, WALK, ADD, HOLD} eng_state_t;
  typedef logic [$clog2(max_features / feats_per_beat)-1:0] beat_idx_t;
  typedef logic [$clog2(beats_per_tree_max)-1:0] heap_idx_t;

  eng_state_t  state;
  logic [31:0] tree_mem [max_trees * beats_per_tree_max];
  feature_t    feat_buf [max_features];
  node_addr_t  wr_addr;
  node_addr_t  base;
  node_addr_t  leaf_first;
  node_addr_t  stride;
  node_addr_t  leaf_addr;
  beat_idx_t   beat_idx;
  beat_idx_t   beat_last;
  heap_idx_t   node;
  heap_idx_t   child;
  depth_t      level;
  tree_cnt_t   tree_idx;
  result_t     acc;
  logic        leaf_pend;
  logic [31:0] node_word;
  logic [31:0] leaf_word;
  feat_idx_t   sel_idx;
  threshold_t  thresh;
  logic        go_left;
  logic        tuple_fire;
  logic        tuple_end;
  logic        tree_end;

  ////////////////////////////////////////////////////////////////////////////
  // Tree memory and tuple buffer
  ////////////////////////////////////////////////////////////////////////////

  // 2^depth - 1 internal nodes, stride adds the leaves
  assign leaf_first = node_addr_t'(nodes_per_tree_max >> (max_depth - int'(cfg.tree_depth)));
  assign stride     = (leaf_first << 1) + node_addr_t'(1);
  assign beat_last  = beat_idx_t'((int'(cfg.num_features) - 1) / feats_per_beat);

  // Trees packed back to back, so tree t lands at t x stride
  always_ff @(posedge aclk) begin
    if (!aresetn) wr_addr <= '0;
    else if (start) wr_addr <= '0;
    else if (tree_wr_valid) wr_addr <= wr_addr + node_addr_t'(1);
  end

  always_ff @(posedge aclk) begin
    if (tree_wr_valid) tree_mem[wr_addr] <= tree_data[31:0];
  end

  assign tuple_ready = (state == FILL);
  assign tuple_fire  = tuple_valid && tuple_ready;
  assign tuple_end   = (beat_idx == beat_last) || tuple_last;

  always_ff @(posedge aclk) begin
    if (tuple_fire) begin
      for (int k = 0; k < feats_per_beat; k++) begin
        feat_buf[int'(beat_idx) * feats_per_beat + k] <=
          feature_t'(tuple_data[$bits(feature_t) * k +: $bits(feature_t)]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tree walk
  ////////////////////////////////////////////////////////////////////////////

  // Two read ports, node of this level and leaf of the previous tree
  assign node_word = tree_mem[base + node_addr_t'(node)];
  assign leaf_word = tree_mem[leaf_addr];
  assign sel_idx   = node_word[3:0];
  assign thresh    = threshold_t'(node_word[31:16]);
  // Signed compare, equality goes right
  assign go_left   = feat_buf[sel_idx] < thresh;
  assign child     = (node << 1) + (go_left ? heap_idx_t'(1) : heap_idx_t'(2));
  assign tree_end  = (level == cfg.tree_depth - depth_t'(1));

  assign res       = acc;
  assign res_valid = (state == HOLD);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= FILL;
      beat_idx <= '0;
    end else if (start) begin
      state    <= FILL;
      beat_idx <= '0;
    end else begin
      case (state)
        FILL: begin
          if (tuple_fire) begin
            beat_idx <= tuple_end ? beat_idx_t'(0) : beat_idx + beat_idx_t'(1);
            if (tuple_end) state <= WALK;
          end
        end
        WALK: begin
          if (tree_end && tree_idx == cfg.num_trees - tree_cnt_t'(1)) state <= ADD;
        end
        // Last leaf of the last tree
        ADD:     state <= HOLD;
        HOLD:    if (res_ready) state <= FILL;
        default: state <= FILL;
      endcase
    end
  end

  // Walk datapath, loaded when a tuple completes
  always_ff @(posedge aclk) begin
    case (state)
      FILL: begin
        base      <= '0;
        node      <= '0;
        level     <= '0;
        tree_idx  <= '0;
        acc       <= '0;
        leaf_pend <= 1'b0;
      end
      WALK: begin
        if (leaf_pend) acc <= acc + result_t'(leaf_word);
        leaf_pend <= tree_end;
        if (tree_end) begin
          // Heap index i is the leaf at i - leaf_first after the nodes
          leaf_addr <= base + node_addr_t'(child);
          base      <= base + stride;
          node      <= '0;
          level     <= '0;
          tree_idx  <= tree_idx + tree_cnt_t'(1);
        end else begin
          node  <= child;
          level <= level + depth_t'(1);
        end
      end
      ADD:     acc <= acc + result_t'(leaf_word);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* src/dtree_result_packer.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_result_packer (
  input  wire                          aclk,
  input  wire                          aresetn,
  input  wire dtree_cfg_pkg::job_cfg_t cfg,
  input  wire                          start,
  input  wire dtree_cfg_pkg::result_t  res,
  input  wire                          res_valid,
  output logic                         res_ready,
  output dtree_bus_pkg::axis_beat_t    out_beat,
  output logic                         out_valid,
  input  wire                          out_ready,
  output logic                         job_done
);

  import dtree_cfg_pkg::*;

  result_t    low_q;
  logic       have_low;
  tuple_cnt_t res_cnt;
  tuple_cnt_t cnt_next;
  logic       res_fire;
  logic       is_final;
  logic       emit;

  // Stalled output holds the engine result
  assign res_ready = !out_valid || out_ready;
  assign res_fire  = res_valid && res_ready;
  assign cnt_next  = res_cnt + tuple_cnt_t'(1);
  assign is_final  = (cnt_next == cfg.num_tuples);
  // Full pair, or half beat flushed at the end
  assign emit      = have_low || is_final;
  assign job_done  = out_valid && out_ready && out_beat.tlast;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
      have_low  <= 1'b0;
      res_cnt   <= '0;
    end else begin
      if (out_valid && out_ready) out_valid <= 1'b0;
      if (start) begin
        have_low <= 1'b0;
        res_cnt  <= '0;
      end else if (res_fire) begin
        res_cnt  <= cnt_next;
        have_low <= !emit;
        if (emit) out_valid <= 1'b1;
      end
    end
  end

  // First result of a pair in the low half
  always_ff @(posedge aclk) begin
    if (res_fire) begin
      low_q <= res;
      if (emit) begin
        out_beat.tdata <= have_low ? {res, low_q} : {32'd0, res};
        out_beat.tkeep <= have_low ? 8'hFF : 8'h0F;
        out_beat.tlast <= is_final;
      end
    end
  end

endmodule

`default_nettype wire

/* src/dtree_accel_top.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_accel_top (
  input  wire                            aclk,
  input  wire                            aresetn,
  input  wire dtree_bus_pkg::axil_req_t  axil_req,
  output dtree_bus_pkg::axil_rsp_t       axil_rsp,
  input  wire dtree_bus_pkg::axis_beat_t s_beat,
  input  wire                            s_valid,
  output logic                           s_ready,
  output dtree_bus_pkg::axis_beat_t      m_beat,
  output logic                           m_valid,
  input  wire                            m_ready
);

  import dtree_cfg_pkg::*;
  import dtree_bus_pkg::*;

  job_cfg_t               cfg;
  logic                   start;
  logic                   job_done;
  axis_beat_t             sink_beat;
  logic                   sink_valid;
  logic                   sink_ready;
  logic                   tree_wr_valid;
  logic [axis_data_w-1:0] tree_data;
  logic                   tuple_valid;
  logic                   tuple_ready;
  logic [axis_data_w-1:0] tuple_data;
  logic                   tuple_last;
  result_t                res;
  logic                   res_valid;
  logic                   res_ready;
  axis_beat_t             pk_beat;
  logic                   pk_valid;
  logic                   pk_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Control port and host streams
  ////////////////////////////////////////////////////////////////////////////

  dtree_csr csr0 (.aclk, .aresetn, .axil_req, .axil_rsp, .job_done, .cfg, .start);

  axis_reg_slice #(.beat_t(axis_beat_t)) sink_slice (
    .aclk, .aresetn,
    .in_beat(s_beat), .in_valid(s_valid), .in_ready(s_ready),
    .out_beat(sink_beat), .out_valid(sink_valid), .out_ready(sink_ready)
  );

  axis_reg_slice #(.beat_t(axis_beat_t)) src_slice (
    .aclk, .aresetn,
    .in_beat(pk_beat), .in_valid(pk_valid), .in_ready(pk_ready),
    .out_beat(m_beat), .out_valid(m_valid), .out_ready(m_ready)
  );

  // Reader phase flag stays local, CSR keeps its own busy
  dtree_input_sequencer seq0 (
    .aclk, .aresetn, .start,
    .in_beat(sink_beat), .in_valid(sink_valid), .in_ready(sink_ready),
    .tree_wr_valid, .tree_data,
    .tuple_valid, .tuple_ready, .tuple_data, .tuple_last,
    .busy()
  );

  dtree_engine engine0 (
    .aclk, .aresetn, .cfg, .start,
    .tree_wr_valid, .tree_data,
    .tuple_valid, .tuple_ready, .tuple_data, .tuple_last,
    .res, .res_valid, .res_ready
  );

  dtree_result_packer packer0 (
    .aclk, .aresetn, .cfg, .start,
    .res, .res_valid, .res_ready,
    .out_beat(pk_beat), .out_valid(pk_valid), .out_ready(pk_ready),
    .job_done
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 50,
  parameter int reset_cycles = 4
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(half_period) aclk = ~aclk;
  end

  // Reset released just after an edge
  initial begin
    aresetn = 1'b0;
    repeat (reset_cycles) @(posedge aclk);
    #1 aresetn = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/dtree_asserts.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_asserts (
  input wire                            aclk,
  input wire                            aresetn,
  input wire dtree_bus_pkg::axis_beat_t s_beat,
  input wire                            s_valid,
  input wire                            s_ready,
  input wire dtree_bus_pkg::axis_beat_t m_beat,
  input wire                            m_valid,
  input wire                            m_ready
);

  // Host input, beat held while stalled
  s_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_valid && !s_ready |=> s_valid && $stable(s_beat))
    else $error("input stream dropped or changed a stalled beat");

  // Result output, same rule
  m_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("output stream dropped or changed a stalled beat");

  m_reset: assert property (@(posedge aclk) !aresetn |=> !m_valid)
    else $error("output valid high in reset");

  // Partial keep only on the closing beat
  m_keep: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_beat.tlast |-> m_beat.tkeep == 8'hFF)
    else $error("partial tkeep on a beat without tlast");

endmodule

bind dtree_accel_top dtree_asserts asserts0 (.*);

`default_nettype wire

/* bench/dtree_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module dtree_tb;

  import dtree_cfg_pkg::*;
  import dtree_bus_pkg::*;

  logic       aclk;
  logic       aresetn;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;
  axis_beat_t s_beat;
  logic       s_valid;
  logic       s_ready;
  axis_beat_t m_beat;
  logic       m_valid;
  logic       m_ready;

  // Job model indexed [tree][node] and [tuple][feature]
  int node_feat [max_trees][nodes_per_tree_max];
  int node_thr  [max_trees][nodes_per_tree_max];
  int leaf_val  [max_trees][nodes_per_tree_max + 1];
  int feats     [16][max_features];

  axis_beat_t  in_q[$];
  logic [63:0] exp_data[$];
  logic [7:0]  exp_keep[$];
  logic        exp_last[$];
  string       test_name;
  logic        bp_on;
  int          error_count;
  int          cycles;
  int          cycle_limit;

  tb_clock_gen clk0 (.aclk, .aresetn);

  dtree_accel_top dut0 (
    .aclk, .aresetn, .axil_req, .axil_rsp,
    .s_beat, .s_valid, .s_ready, .m_beat, .m_valid, .m_ready
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  // Heap walk where strictly less goes left
  function automatic logic [31:0] dtree_ref(input int tup, input int ntrees, input int depth);
    logic [31:0] sum;
    int          i;
    sum = '0;
    for (int t = 0; t < ntrees; t++) begin
      i = 0;
      for (int l = 0; l < depth; l++) begin
        if (feats[tup][node_feat[t][i]] < node_thr[t][i]) i = 2 * i + 1;
        else i = 2 * i + 2;
      end
      sum = sum + 32'(leaf_val[t][i - ((1 << depth) - 1)]);
    end
    return sum;
  endfunction

  function automatic int job_budget(input int tree_beats, input int tuple_beats,
                                    input int trees, input int depth);
    return tree_beats + tuple_beats * (trees * depth + 2) + 50;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s / %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "check failed");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite host
  ////////////////////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wvalid  = 1'b1;
    while (!axil_rsp.awready || !axil_rsp.wready) begin
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    // bready stays high so the response goes on the next edge
    while (!axil_rsp.bvalid) begin
      @(posedge aclk);
      #1;
    end
    check_value("bresp", 64'd0, 64'(axil_rsp.bresp));
    @(posedge aclk);
    #1;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    while (!axil_rsp.arready) begin
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);
    #1;
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) begin
      @(posedge aclk);
      #1;
    end
    data = axil_rsp.rdata;
    check_value("rresp", 64'd0, 64'(axil_rsp.rresp));
    @(posedge aclk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Job building
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_random(input int nf, input int depth, input int ntrees, input int ntup);
    for (int t = 0; t < ntrees; t++) begin
      for (int n = 0; n < (1 << depth) - 1; n++) begin
        node_feat[t][n] = int'($urandom % nf);
        node_thr[t][n]  = int'($urandom % 2001) - 1000;
      end
      for (int l = 0; l < (1 << depth); l++) leaf_val[t][l] = int'($urandom);
    end
    for (int j = 0; j < ntup; j++) begin
      for (int f = 0; f < nf; f++) feats[j][f] = int'($urandom % 2001) - 1000;
    end
  endtask

  // Trees in heap order followed by tuples of four features per beat
  task automatic load_stream(input int nf, input int depth, input int ntrees, input int ntup);
    axis_beat_t b;
    int         nodes;
    int         nbeats;
    nodes  = (1 << depth) - 1;
    nbeats = (nf + 3) / 4;
    for (int t = 0; t < ntrees; t++) begin
      for (int n = 0; n < nodes; n++) begin
        b = '0;
        b.tkeep = 8'hFF;
        b.tdata[3:0]   = 4'(node_feat[t][n]);
        b.tdata[31:16] = 16'(node_thr[t][n]);
        in_q.push_back(b);
      end
      for (int l = 0; l <= nodes; l++) begin
        b = '0;
        b.tkeep = 8'hFF;
        b.tdata[31:0] = 32'(leaf_val[t][l]);
        b.tlast = (t == ntrees - 1) && (l == nodes);
        in_q.push_back(b);
      end
    end
    for (int j = 0; j < ntup; j++) begin
      for (int bi = 0; bi < nbeats; bi++) begin
        b = '0;
        b.tkeep = 8'hFF;
        for (int k = 0; k < 4; k++) begin
          if (4 * bi + k < nf) b.tdata[16 * k +: 16] = 16'(feats[j][4 * bi + k]);
        end
        b.tlast = (j == ntup - 1) && (bi == nbeats - 1);
        in_q.push_back(b);
      end
    end
  endtask

  // Two results per beat and a half beat for an odd count
  task automatic expect_results(input int depth, input int ntrees, input int ntup);
    logic [31:0] r0;
    logic [31:0] r1;
    for (int j = 0; j < ntup; j += 2) begin
      r0 = dtree_ref(j, ntrees, depth);
      if (j + 1 < ntup) begin
        r1 = dtree_ref(j + 1, ntrees, depth);
        exp_data.push_back({r1, r0});
        exp_keep.push_back(8'hFF);
      end else begin
        exp_data.push_back({32'd0, r0});
        exp_keep.push_back(8'h0F);
      end
      exp_last.push_back(j + 2 >= ntup);
    end
  endtask

  task automatic run_job(input int nf, input int depth, input int ntrees, input int ntup,
                         input logic extra_start);
    logic [31:0] rd;
    axil_write(reg_num_features, 32'(nf));
    axil_write(reg_tree_depth, 32'(depth));
    axil_write(reg_num_trees, 32'(ntrees));
    axil_write(reg_num_tuples, 32'(ntup));
    expect_results(depth, ntrees, ntup);
    load_stream(nf, depth, ntrees, ntup);
    axil_write(reg_ctrl, 32'd1);
    if (extra_start) begin
      axil_read(reg_ctrl, rd);
      check_value("busy during job", 64'd1, 64'(rd));
      // Ignored by the DUT so no second set of results may appear
      axil_write(reg_ctrl, 32'd1);
    end
    while (exp_data.size() > 0) begin
      @(posedge aclk);
      #1;
    end
    // Quiet window that exposes any extra output beat
    repeat (20) @(posedge aclk);
    #1;
    axil_read(reg_ctrl, rd);
    check_value("status after job", 64'd2, 64'(rd));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream processes
  ////////////////////////////////////////////////////////////////////////////

  // Feeder with random gaps only between beats
  initial begin : feed
    logic in_fire;
    s_valid = 1'b0;
    s_beat  = '0;
    forever begin
      @(negedge aclk);
      in_fire = s_valid && s_ready;
      @(posedge aclk);
      #1;
      if (in_fire) void'(in_q.pop_front());
      if (!(s_valid && !in_fire)) begin
        if (in_q.size() > 0 && (!bp_on || ($urandom % 4) != 0)) begin
          s_beat  = in_q[0];
          s_valid = 1'b1;
        end else begin
          s_valid = 1'b0;
        end
      end
    end
  end

  // One expected beat per output beat
  initial begin : compare
    logic [63:0] mask;
    m_ready = 1'b0;
    forever begin
      @(negedge aclk);
      if (m_valid && m_ready) begin
        if (exp_data.size() == 0) begin
          error_count++;
          $display("Output beat arrived with no result expected in %s", test_name);
          $display("=== FAIL ===");
          $fatal(1, "extra output beat");
        end else begin
          for (int k = 0; k < 8; k++) mask[8 * k +: 8] = {8{exp_keep[0][k]}};
          check_value("tdata", exp_data[0], m_beat.tdata & mask);
          check_value("tkeep", 64'(exp_keep[0]), 64'(m_beat.tkeep));
          check_value("tlast", 64'(exp_last[0]), 64'(m_beat.tlast));
          void'(exp_data.pop_front());
          void'(exp_keep.pop_front());
          void'(exp_last.pop_front());
        end
      end
      @(posedge aclk);
      #1;
      m_ready = aresetn && (!bp_on || ($urandom % 3) != 0);
    end
  end

  initial begin : watchdog
    cycles = 0;
    forever begin
      @(posedge aclk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout after %0d cycles in %s", cycles, test_name);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd;
    void'($urandom(32'hc0cad7ce));
    error_count = 0;
    cycle_limit = job_budget(0, 0, 0, 0) + job_budget(3, 6, 1, 1)
                + 2 * job_budget(248, 36, 8, 4) + job_budget(75, 18, 5, 3);
    axil_req = '0;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    bp_on = 1'b0;
    test_name = "reset";
    wait (aresetn);
    @(posedge aclk);
    #1;

    test_name = "register readback";
    axil_read(reg_ctrl, rd);
    check_value("ctrl after reset", 64'd0, 64'(rd));
    axil_write(reg_num_features, 32'd11);
    axil_write(reg_tree_depth, 32'd3);
    axil_write(reg_num_trees, 32'd6);
    axil_write(reg_num_tuples, 32'h0001_2345);
    axil_read(reg_num_features, rd);
    check_value("num_features", 64'd11, 64'(rd));
    axil_read(reg_tree_depth, rd);
    check_value("tree_depth", 64'd3, 64'(rd));
    axil_read(reg_num_trees, rd);
    check_value("num_trees", 64'd6, 64'(rd));
    axil_read(reg_num_tuples, rd);
    check_value("num_tuples", 64'h0001_2345, 64'(rd));
    // Past the register map
    axil_read(8'h14, rd);
    check_value("unmapped address", 64'd0, 64'(rd));

    // Depth 1 on feature 2 where equality goes right
    test_name = "single tree";
    node_feat[0][0] = 2;
    node_thr[0][0]  = -5;
    leaf_val[0][0]  = 100;
    leaf_val[0][1]  = 200;
    for (int j = 0; j < 6; j++) begin
      for (int f = 0; f < 4; f++) feats[j][f] = int'($urandom % 2001) - 1000;
    end
    feats[0][2] = -6;
    feats[1][2] = -5;
    feats[2][2] = -4;
    feats[3][2] = 0;
    feats[4][2] = -32768;
    feats[5][2] = 32767;
    run_job(4, 1, 1, 6, 1'b0);

    test_name = "random job";
    fill_random(16, 4, 8, 9);
    run_job(16, 4, 8, 9, 1'b0);

    // Same trees and tuples under stalls
    test_name = "back-pressure";
    bp_on = 1'b1;
    run_job(16, 4, 8, 9, 1'b1);
    bp_on = 1'b0;

    test_name = "second job";
    fill_random(10, 3, 5, 6);
    run_job(10, 3, 5, 6, 1'b0);

    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/dtree_cfg_pkg.sv
src/dtree_bus_pkg.sv
src/axis_reg_slice.sv
src/dtree_csr.sv
src/dtree_input_sequencer.sv
src/dtree_engine.sv
src/dtree_result_packer.sv
src/dtree_accel_top.sv
bench/tb_clock_gen.sv
bench/dtree_asserts.sv
bench/dtree_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dtree_tb -f filelist.f \
  --Mdir obj_dir -o dtree_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/dtree_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "=== PASS ===" <<< "$sim_out"; then
  exit 0
fi
exit 1
